/* Bender.yml */
package:
  name: vec_repeat

sources:
  - src/repeat_pkg.sv
  - src/simple_dual_port_ram.sv
  - src/register_slice.sv
  - src/repeat_circular_buffer.sv
  - src/lane_combiner.sv
  - src/vec_repeat_top.sv
  - target: test
    files:
      - test/vec_repeat_assert.sv
      - test/vec_repeat_tb.sv

/* src/lane_combiner.sv */
/* Two lane stream join with an add, subtract or multiply
   stage feeding a registered result */

`timescale 1ns/10ps
`default_nettype none

module lane_combiner #(
    parameter int DATA_WIDTH = repeat_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    input  repeat_pkg::op_t       op,

    // Lane a
    input  logic [DATA_WIDTH-1:0] a_data,
    input  logic                  a_valid,
    output logic                  a_ready,

    // Lane b
    input  logic [DATA_WIDTH-1:0] b_data,
    input  logic                  b_valid,
    output logic                  b_ready,

    // Result stream
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    import repeat_pkg::*;

    logic                  fire;
    logic [DATA_WIDTH-1:0] result;

    // Both lanes must be present and the result register free
    assign fire    = a_valid && b_valid && (!out_valid || out_ready);
    assign a_ready = fire;
    assign b_ready = fire;

    // All results wrap modulo 2^DATA_WIDTH
    always_comb begin
        case (op)
            OP_ADD:  result = a_data + b_data;
            OP_SUB:  result = a_data - b_data;
            // Product truncated to the low DATA_WIDTH bits by context width
            OP_MUL:  result = a_data * b_data;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_data <= result;
        end
    end

endmodule

`default_nettype wire

/* src/register_slice.sv */
/* Single entry valid/ready pipeline register
   with registered data and valid toward the sink */

`timescale 1ns/10ps
`default_nettype none

module register_slice #(
    parameter int DATA_WIDTH = repeat_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    // Upstream side
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,

    // Downstream side
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    logic load;

    // Room when empty or when the held word leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* src/repeat_circular_buffer.sv */
/* Repeating circular buffer: stores a block of SIZE words and replays it
   REPEAT times, with a spill register covering the RAM read latency */

`timescale 1ns/10ps
`default_nettype none

module repeat_circular_buffer #(
    parameter int DATA_WIDTH = repeat_pkg::DEFAULT_DATA_WIDTH,
    parameter int REPEAT     = repeat_pkg::DEFAULT_REPEAT,
    parameter int SIZE       = repeat_pkg::DEFAULT_SIZE
) (
    input  logic                  clk,
    input  logic                  rst,

    // Block input stream
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,

    // Replayed output stream
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    localparam int ADDR_WIDTH = (SIZE == 1) ? 1 : $clog2(SIZE);
    // Extra bit so the pointer can reach SIZE once the block is written
    localparam int PTR_WIDTH  = ADDR_WIDTH + 1;
    localparam int REP_WIDTH  = (REPEAT < 2) ? 1 : $clog2(REPEAT);

    localparam logic [PTR_WIDTH-1:0]  FULL_COUNT = PTR_WIDTH'(SIZE);
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR  = ADDR_WIDTH'(SIZE - 1);
    localparam logic [REP_WIDTH-1:0]  LAST_REP   = REP_WIDTH'(REPEAT - 1);

    if (REPEAT < 2) begin : g_bad_repeat
        $error("repeat_circular_buffer needs REPEAT of at least 2");
    end

    // Write side state
    logic [PTR_WIDTH-1:0]  write_ptr, write_ptr_next;
    logic [PTR_WIDTH-1:0]  count, count_next;

    // Read side state
    logic [ADDR_WIDTH-1:0] read_ptr, read_ptr_next;
    logic [REP_WIDTH-1:0]  rep, rep_next;
    logic                  rd_valid, rd_valid_next;

    // Spill register for a word leaving the RAM while reads pause
    logic                  spill_valid, spill_valid_next;
    logic [DATA_WIDTH-1:0] spill_data;
    logic                  spill_load;

    logic                  wr_en;
    logic                  read_issue;
    logic                  pause_reads;
    logic [DATA_WIDTH-1:0] ram_rd_dout;

    // Signals into the output slice
    logic [DATA_WIDTH-1:0] slice_in_data;
    logic                  slice_in_valid;
    logic                  slice_in_ready;

    // Accept only during the fill, before any second pass starts
    assign in_ready = (rep == '0) && (count != FULL_COUNT);
    assign wr_en    = in_valid && in_ready;

    // Hold off reads when the slice is stuck full or the spill is occupied
    assign pause_reads = (!out_ready && out_valid) || spill_valid;
    assign read_issue  = ({1'b0, read_ptr} < write_ptr) && !pause_reads;

    // RAM word arriving while reads are paused has nowhere else to go
    assign spill_load = pause_reads && rd_valid;

    always_comb begin
        write_ptr_next   = write_ptr;
        count_next       = count;
        read_ptr_next    = read_ptr;
        rep_next         = rep;
        rd_valid_next    = read_issue;
        spill_valid_next = spill_valid;

        if (wr_en) begin
            write_ptr_next = write_ptr + 1'b1;
            count_next     = count + 1'b1;
        end

        if (read_issue) begin
            if (read_ptr == LAST_ADDR && rep == LAST_REP) begin
                // Last read of the last pass frees the buffer for the next block
                write_ptr_next = '0;
                count_next     = '0;
                read_ptr_next  = '0;
                rep_next       = '0;
            end else if (read_ptr == LAST_ADDR) begin
                read_ptr_next = '0;
                rep_next      = rep + 1'b1;
            end else begin
                read_ptr_next = read_ptr + 1'b1;
            end
        end

        if (spill_load) begin
            spill_valid_next = 1'b1;
        end else if (spill_valid && slice_in_ready) begin
            spill_valid_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            write_ptr   <= '0;
            count       <= '0;
            read_ptr    <= '0;
            rep         <= '0;
            rd_valid    <= 1'b0;
            spill_valid <= 1'b0;
        end else begin
            write_ptr   <= write_ptr_next;
            count       <= count_next;
            read_ptr    <= read_ptr_next;
            rep         <= rep_next;
            rd_valid    <= rd_valid_next;
            spill_valid <= spill_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (spill_load) begin
            spill_data <= ram_rd_dout;
        end
    end

    // Spilled word always goes first, the RAM is idle meanwhile
    assign slice_in_data  = spill_valid ? spill_data : ram_rd_dout;
    assign slice_in_valid = spill_valid || rd_valid;

    simple_dual_port_ram #(
        .DATA_WIDTH (DATA_WIDTH),
        .SIZE       (SIZE)
    ) ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (write_ptr[ADDR_WIDTH-1:0]),
        .wr_din  (in_data),
        .rd_addr (read_ptr),
        .rd_dout (ram_rd_dout)
    );

    register_slice #(
        .DATA_WIDTH (DATA_WIDTH)
    ) out_slice (
        .clk       (clk),
        .rst       (rst),
        .in_data   (slice_in_data),
        .in_valid  (slice_in_valid),
        .in_ready  (slice_in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* src/repeat_pkg.sv */
/* Shared definitions for the vector replay datapath:
   combiner opcode type and default parameter values */

`default_nettype none

package repeat_pkg;

    // Combiner operation, held stable while a block is in flight
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } op_t;

    // Defaults for the top level parameters
    localparam int DEFAULT_DATA_WIDTH = 16;
    localparam int DEFAULT_REPEAT     = 3;
    localparam int DEFAULT_SIZE       = 4;

endpackage

`default_nettype wire

/* src/simple_dual_port_ram.sv */
/* Simple dual port RAM, one write port and one read port
   with a registered read of one cycle latency */

`timescale 1ns/10ps
`default_nettype none

module simple_dual_port_ram #(
    parameter int   DATA_WIDTH = repeat_pkg::DEFAULT_DATA_WIDTH,
    parameter int   SIZE       = repeat_pkg::DEFAULT_SIZE,
    localparam int  ADDR_WIDTH = (SIZE == 1) ? 1 : $clog2(SIZE)
) (
    input  logic                  clk,

    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_din,

    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [DATA_WIDTH-1:0] rd_dout
);

    logic [DATA_WIDTH-1:0] mem [SIZE];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_din;
        end
    end

    // Read port always active, caller tracks which cycles matter
    always_ff @(posedge clk) begin
        rd_dout <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* src/vec_repeat_top.sv */
/* Vector replay combiner top level: two repeating buffers
   side by side feeding the lane combiner */

`timescale 1ns/10ps
`default_nettype none

module vec_repeat_top #(
    parameter int DATA_WIDTH = repeat_pkg::DEFAULT_DATA_WIDTH,
    parameter int REPEAT     = repeat_pkg::DEFAULT_REPEAT,
    parameter int SIZE       = repeat_pkg::DEFAULT_SIZE
) (
    input  logic                  clk,
    input  logic                  rst,

    input  repeat_pkg::op_t       op,

    // Operand stream a
    input  logic [DATA_WIDTH-1:0] a_data,
    input  logic                  a_valid,
    output logic                  a_ready,

    // Operand stream b
    input  logic [DATA_WIDTH-1:0] b_data,
    input  logic                  b_valid,
    output logic                  b_ready,

    // Combined result stream
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    // Replayed operand streams
    logic [DATA_WIDTH-1:0] rep_a_data;
    logic                  rep_a_valid;
    logic                  rep_a_ready;
    logic [DATA_WIDTH-1:0] rep_b_data;
    logic                  rep_b_valid;
    logic                  rep_b_ready;

    repeat_circular_buffer #(
        .DATA_WIDTH (DATA_WIDTH),
        .REPEAT     (REPEAT),
        .SIZE       (SIZE)
    ) buffer_a (
        .clk       (clk),
        .rst       (rst),
        .in_data   (a_data),
        .in_valid  (a_valid),
        .in_ready  (a_ready),
        .out_data  (rep_a_data),
        .out_valid (rep_a_valid),
        .out_ready (rep_a_ready)
    );

    repeat_circular_buffer #(
        .DATA_WIDTH (DATA_WIDTH),
        .REPEAT     (REPEAT),
        .SIZE       (SIZE)
    ) buffer_b (
        .clk       (clk),
        .rst       (rst),
        .in_data   (b_data),
        .in_valid  (b_valid),
        .in_ready  (b_ready),
        .out_data  (rep_b_data),
        .out_valid (rep_b_valid),
        .out_ready (rep_b_ready)
    );

    // Consumes one word from each lane per result
    lane_combiner #(
        .DATA_WIDTH (DATA_WIDTH)
    ) combiner (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .a_data    (rep_a_data),
        .a_valid   (rep_a_valid),
        .a_ready   (rep_a_ready),
        .b_data    (rep_b_data),
        .b_valid   (rep_b_valid),
        .b_ready   (rep_b_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* tb.f */
src/repeat_pkg.sv
src/simple_dual_port_ram.sv
src/register_slice.sv
src/repeat_circular_buffer.sv
src/lane_combiner.sv
src/vec_repeat_top.sv
test/vec_repeat_assert.sv
test/vec_repeat_tb.sv

/* test/vec_repeat_assert.sv */
/* Concurrent assertions on the top level stream handshakes,
   bound into the vector replay top */

`timescale 1ns/10ps
`default_nettype none

module vec_repeat_assert #(
    parameter int  DATA_WIDTH  = repeat_pkg::DEFAULT_DATA_WIDTH,
    parameter int  REPEAT      = repeat_pkg::DEFAULT_REPEAT,
    parameter int  SIZE        = repeat_pkg::DEFAULT_SIZE,
    localparam int BLOCK_WORDS = SIZE * REPEAT
) (
    input logic                  clk,
    input logic                  rst,
    input logic [DATA_WIDTH-1:0] out_data,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic                  a_valid,
    input logic                  a_ready,
    input logic                  b_valid,
    input logic                  b_ready,
    input logic                  rep_valid,
    input logic                  rep_ready
);

    // Words accepted per input and replayed pairs taken by the combiner
    int unsigned a_taken;
    int unsigned b_taken;
    int unsigned pairs_taken;
    int unsigned failures = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_taken     <= 0;
            b_taken     <= 0;
            pairs_taken <= 0;
        end else begin
            if (a_valid && a_ready) begin
                a_taken <= a_taken + 1;
            end
            if (b_valid && b_ready) begin
                b_taken <= b_taken + 1;
            end
            if (rep_valid && rep_ready) begin
                pairs_taken <= pairs_taken + 1;
            end
        end
    end

    // Result held steady while the sink stalls
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        $error("out stream dropped or changed a word while stalled");
        failures++;
    end

    assert property (@(posedge clk) rst |=> !out_valid)
    else begin
        $error("out_valid high in the cycle after reset");
        failures++;
    end

    // Whole block stored and its replay not yet finished.
    // At most two replayed words sit past the RAM once a buffer frees up
    assert property (@(posedge clk) disable iff (rst)
        (a_taken != 0) && ((a_taken % SIZE) == 0) &&
        ((pairs_taken + 2) < (a_taken / SIZE) * BLOCK_WORDS) |-> !a_ready)
    else begin
        $error("a_ready high while a block is held for replay");
        failures++;
    end

    assert property (@(posedge clk) disable iff (rst)
        (b_taken != 0) && ((b_taken % SIZE) == 0) &&
        ((pairs_taken + 2) < (b_taken / SIZE) * BLOCK_WORDS) |-> !b_ready)
    else begin
        $error("b_ready high while a block is held for replay");
        failures++;
    end

endmodule

bind vec_repeat_top vec_repeat_assert #(
    .DATA_WIDTH (DATA_WIDTH),
    .REPEAT     (REPEAT),
    .SIZE       (SIZE)
) handshake_checks (
    .clk       (clk),
    .rst       (rst),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .rep_valid (rep_a_valid),
    .rep_ready (rep_a_ready)
);

`default_nettype wire

/* test/vec_repeat_tb.sv */
/* Testbench for the vector replay combiner: LFSR stimulus, reference model,
   output comparison, back-pressure, mid-stream reset and a watchdog */

`timescale 1ns/10ps
`default_nettype none

module vec_repeat_tb;

    import repeat_pkg::*;

    localparam int DATA_WIDTH   = DEFAULT_DATA_WIDTH;
    localparam int REPEAT       = DEFAULT_REPEAT;
    localparam int SIZE         = DEFAULT_SIZE;
    localparam int WIDE         = 2 * DATA_WIDTH;
    localparam int CLK_PERIOD   = 40;
    localparam int BLOCK_WORDS  = SIZE * REPEAT;

    // Blocks sent over the whole run, and cycles allowed per output word
    localparam int TOTAL_BLOCKS = 19;
    localparam int WORD_MARGIN  = 10;
    localparam int TIMEOUT_NS   = (TOTAL_BLOCKS * BLOCK_WORDS * WORD_MARGIN + 200) * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  rst;
    op_t                   op;
    logic [DATA_WIDTH-1:0] a_data;
    logic                  a_valid;
    logic                  a_ready;
    logic [DATA_WIDTH-1:0] b_data;
    logic                  b_valid;
    logic                  b_ready;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_valid;
    logic                  out_ready;

    logic [31:0]           lfsr = 32'h807a5c4c;

    // Blocks recorded since the last reset
    op_t                   blk_op[$];
    logic [DATA_WIDTH-1:0] a_words[$];
    logic [DATA_WIDTH-1:0] b_words[$];

    int                    out_count;
    int                    a_accepted;
    int                    b_accepted;
    bit                    stall_outputs;
    string                 test_name;

    always #(CLK_PERIOD / 2) clk = ~clk;

    vec_repeat_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .REPEAT     (REPEAT),
        .SIZE       (SIZE)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .a_data    (a_data),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .b_data    (b_data),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // Arithmetic modulo 2^DATA_WIDTH, worked in a double width
    function automatic logic [DATA_WIDTH-1:0] expected_result(input op_t sel,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        logic [WIDE-1:0] wide;
        case (sel)
            OP_ADD:  wide = WIDE'(a) + WIDE'(b);
            OP_SUB:  wide = WIDE'(a) + WIDE'(~b) + WIDE'(1);
            OP_MUL:  wide = WIDE'(a) * WIDE'(b);
            default: wide = '0;
        endcase
        return wide[DATA_WIDTH-1:0];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("error: %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic record_block(input op_t sel);
        blk_op.push_back(sel);
        for (int i = 0; i < SIZE; i++) begin
            a_words.push_back(DATA_WIDTH'(random_bits(DATA_WIDTH)));
            b_words.push_back(DATA_WIDTH'(random_bits(DATA_WIDTH)));
        end
    endtask

    task automatic drive_lane(input bit lane, input bit valid, input logic [DATA_WIDTH-1:0] data);
        if (lane) begin
            b_valid = valid;
            b_data  = data;
        end else begin
            a_valid = valid;
            a_data  = data;
        end
    endtask

    // Ready depends only on buffer state, so it is settled at the falling edge
    task automatic send_lane(input bit lane, input int blk, input int gap_weight);
        int                    sent;
        bit                    holding;
        logic [DATA_WIDTH-1:0] word;
        sent    = 0;
        holding = 1'b0;
        while (sent < SIZE) begin
            @(negedge clk);
            if (!holding && random_bits(2) < gap_weight) begin
                drive_lane(lane, 1'b0, '0);
            end else begin
                word = lane ? b_words[blk * SIZE + sent] : a_words[blk * SIZE + sent];
                drive_lane(lane, 1'b1, word);
                holding = !(lane ? b_ready : a_ready);
                if (!holding) begin
                    sent++;
                    if (lane) begin
                        b_accepted++;
                    end else begin
                        a_accepted++;
                    end
                end
            end
        end
        @(negedge clk);
        drive_lane(lane, 1'b0, '0);
    endtask

    task automatic wait_for_outputs(input int target);
        while (out_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        repeat (3) @(negedge clk);
        blk_op.delete();
        a_words.delete();
        b_words.delete();
        out_count  = 0;
        a_accepted = 0;
        b_accepted = 0;
        rst = 1'b0;
        check_value("reset out_valid", 32'd0, 32'(out_valid));
        check_value("reset a_ready", 32'd1, 32'(a_ready));
        check_value("reset b_ready", 32'd1, 32'(b_ready));
    endtask

    // Op only changes here, once every earlier output has been seen
    task automatic run_test(input string name, input op_t sel, input int blocks,
            input int gap_a, input int gap_b, input bit stall);
        int first;
        test_name     = name;
        stall_outputs = stall;
        @(negedge clk);
        op    = sel;
        first = blk_op.size();
        for (int k = 0; k < blocks; k++) begin
            record_block(sel);
        end
        for (int k = 0; k < blocks; k++) begin
            fork
                send_lane(1'b0, first + k, gap_a);
                send_lane(1'b1, first + k, gap_b);
            join
        end
        wait_for_outputs(blk_op.size() * BLOCK_WORDS);
        check_value({name, " a accepted"}, 32'(blk_op.size() * SIZE), 32'(a_accepted));
        check_value({name, " b accepted"}, 32'(blk_op.size() * SIZE), 32'(b_accepted));
    endtask

    // Reset lands halfway through the replay of one block
    task automatic interrupt_block();
        int blk;
        test_name     = "mid_reset";
        stall_outputs = 1'b1;
        @(negedge clk);
        op  = OP_ADD;
        blk = blk_op.size();
        record_block(OP_ADD);
        fork
            send_lane(1'b0, blk, 1);
            send_lane(1'b1, blk, 1);
        join
        wait_for_outputs(blk * BLOCK_WORDS + BLOCK_WORDS / 2);
        @(negedge clk);
        reset_dut();
    endtask

    initial begin : compare_outputs
        int                    blk;
        int                    idx;
        int                    limit;
        logic [DATA_WIDTH-1:0] expected;
        forever begin
            @(negedge clk);
            out_ready = stall_outputs ? (random_bits(1) != 0) : 1'b1;
            if (!rst && out_valid && out_ready) begin
                blk = out_count / BLOCK_WORDS;
                idx = out_count % SIZE;
                if (blk >= blk_op.size()) begin
                    abort_run("output transfer seen with no block left to replay");
                end else begin
                    expected = expected_result(blk_op[blk], a_words[blk * SIZE + idx],
                                               b_words[blk * SIZE + idx]);
                    check_value(test_name, 32'(expected), 32'(out_data));
                    out_count++;
                end
            end
            // Inputs may run at most two blocks ahead of the completed outputs
            limit = SIZE * (out_count / BLOCK_WORDS + 2);
            if (!rst && (a_accepted > limit || b_accepted > limit)) begin
                abort_run("an input accepted more words than the replay allows");
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        abort_run($sformatf("timeout after %0d ns with %0d outputs seen", TIMEOUT_NS, out_count));
    end

    initial begin
        rst           = 1'b1;
        op            = OP_ADD;
        a_data        = '0;
        a_valid       = 1'b0;
        b_data        = '0;
        b_valid       = 1'b0;
        out_ready     = 1'b1;
        stall_outputs = 1'b0;
        test_name     = "reset";
        reset_dut();

        run_test("replay_add", OP_ADD, 3, 1, 1, 1'b0);
        run_test("opcode_sub", OP_SUB, 3, 1, 1, 1'b0);
        run_test("opcode_mul", OP_MUL, 3, 1, 1, 1'b1);
        run_test("back_pressure", OP_ADD, 4, 0, 0, 1'b1);
        run_test("uneven_a_slow", OP_SUB, 2, 3, 0, 1'b1);
        run_test("uneven_b_slow", OP_MUL, 2, 0, 3, 1'b0);
        interrupt_block();
        run_test("after_reset", OP_MUL, 1, 1, 2, 1'b1);

        if (dut.handshake_checks.failures == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run("handshake assertions failed during the run");
        end
    end

endmodule

`default_nettype wire
